//--- files.f
verilog/dma_pkg.sv
verilog/dma_fifo.sv
verilog/dma_burst_reshaper.sv
verilog/dma_data_mover.sv
verilog/dma_backend.sv
tests/dma_backend_asserts.sv
tests/tb_dma_backend.sv

//--- Makefile
# Verilator flow for the dma backend testbench

VERILATOR ?= verilator
TOP       ?= tb_dma_backend
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation PASSED

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/tb_dma_backend.sv
// --------------------------------------------------------------------------
// dma backend testbench
// byte memory model with random back-pressure and directed copy tests,
// burst shapes recomputed from the page and burst limit rules
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module tb_dma_backend;

  import dma_pkg::*;

  localparam int          ClkPeriod  = 40;
  localparam int unsigned TbMaxBeats = 8;
  localparam int unsigned BurstBytes = TbMaxBeats * StrbWidth;
  // words moved by tests 1, 2, 4 and 5
  localparam int unsigned TotalWords = 16 + 48 + 3 * 16 + 6 * 20;
  localparam int unsigned WatchdogCycles = TotalWords * 24 + 5 * 200;

  logic       clk_i;
  logic       rst_ni;
  logic       valid_i;
  burst_req_t burst_req_i;
  logic       ready_o;
  ax_chan_t   ar_o;
  logic       ar_valid_o;
  logic       ar_ready_i;
  ax_chan_t   aw_o;
  logic       aw_valid_o;
  logic       aw_ready_i;
  w_chan_t    w_o;
  logic       w_valid_o;
  logic       w_ready_i;
  r_chan_t    r_i;
  logic       r_valid_i;
  logic       r_ready_o;
  logic       b_valid_i;
  logic       b_ready_o;
  logic       backend_idle_o;
  logic       trans_complete_o;

  // memory model state
  logic [7:0]  mem [65536];
  ax_chan_t    rd_q[$];
  ax_chan_t    wr_q[$];
  w_chan_t     wbeat_q[$];
  len_t        r_beat = '0;
  len_t        w_beat = '0;
  int unsigned b_pend = 0;
  logic        r_hs = 1'b0;
  logic        b_hs = 1'b0;
  int unsigned stall_pct = 20;

  // observed and expected bursts of the running test
  ax_chan_t    ar_log[$];
  ax_chan_t    aw_log[$];
  int unsigned ar_done[$];
  addr_t       exp_src[$];
  addr_t       exp_dst[$];
  len_t        exp_len[$];
  int unsigned exp_req[$];

  int unsigned comp_cnt = 0;
  int unsigned base_comp = 0;
  int unsigned full_waits = 0;
  int unsigned base_waits = 0;
  int unsigned req_idx = 0;
  int unsigned err_cnt = 0;
  int unsigned test_errs = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;

  dma_backend #(
    .ReqDepth(4),
    .QueueDepth(4),
    .BufferDepth(8),
    .MaxBeats(TbMaxBeats)
  ) dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  // initial memory byte, mixes every address bit
  function automatic logic [7:0] fill_byte(addr_t a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
  endfunction

  function automatic data_t fill_word(addr_t a);
    data_t w;
    w = '0;
    for (int k = int'(StrbWidth) - 1; k >= 0; k--) begin
      w = (w << 8) | data_t'(fill_byte(a + addr_t'(k)));
    end
    return w;
  endfunction

  // little endian word view of the model
  function automatic data_t mem_word(addr_t a);
    data_t w;
    w = '0;
    for (int k = int'(StrbWidth) - 1; k >= 0; k--) begin
      w = (w << 8) | data_t'(mem[16'(a + addr_t'(k))]);
    end
    return w;
  endfunction

  task automatic store_word(input addr_t a, input data_t d);
    for (int k = 0; k < int'(StrbWidth); k++) begin
      mem[16'(a + addr_t'(k))] = 8'(d >> (8 * k));
    end
  endtask

  function automatic logic ready_roll();
    return $urandom_range(99) >= stall_pct;
  endfunction

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_word(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_len(input len_t got, input len_t exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_count(input int unsigned got, input int unsigned exp,
                             input string what);
    if (got != exp) begin
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // --------------------------------------------------------------------------
  // memory model, handshakes sampled on the rising edge
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin
    w_chan_t wb;
    r_hs = r_valid_i & r_ready_o;
    b_hs = b_valid_i & b_ready_o;
    if (trans_complete_o) comp_cnt++;
    if (ar_valid_o && ar_ready_i) begin
      rd_q.push_back(ar_o);
      ar_log.push_back(ar_o);
      ar_done.push_back(comp_cnt);
    end
    if (aw_valid_o && aw_ready_i) begin
      wr_q.push_back(aw_o);
      aw_log.push_back(aw_o);
    end
    if (w_valid_o && w_ready_i) wbeat_q.push_back(w_o);
    if (r_hs) begin
      if (r_beat == rd_q[0].len) begin
        void'(rd_q.pop_front());
        r_beat = '0;
      end else begin
        r_beat++;
      end
    end
    if (b_hs) b_pend--;
    // w beats may arrive ahead of their aw, so they wait here
    if (wr_q.size() > 0 && wbeat_q.size() > 0) begin
      wb = wbeat_q.pop_front();
      store_word(wr_q[0].addr + (addr_t'(w_beat) << 2), wb.data);
      if (wb.last || w_beat == wr_q[0].len) begin
        if (wb.last) begin
          check_len(w_beat, wr_q[0].len, "w beats in burst");
        end else begin
          $display("w burst at %0t reached its length without w last", $time);
          err_cnt++;
        end
        void'(wr_q.pop_front());
        w_beat = '0;
        b_pend++;
      end else begin
        w_beat++;
      end
    end
  end

  // outputs of the model change on the falling edge
  always @(negedge clk_i) begin
    ar_ready_i = ready_roll();
    aw_ready_i = ready_roll();
    w_ready_i  = ready_roll();
    // a raised valid waits for its handshake
    if (!r_valid_i || r_hs) begin
      if (rd_q.size() > 0 && ready_roll()) begin
        r_valid_i = 1'b1;
        r_i.data  = mem_word(rd_q[0].addr + (addr_t'(r_beat) << 2));
        r_i.last  = (r_beat == rd_q[0].len);
      end else begin
        r_valid_i = 1'b0;
      end
    end
    if (!b_valid_i || b_hs) b_valid_i = (b_pend > 0) && ready_roll();
  end

  // --------------------------------------------------------------------------
  // test flow
  // --------------------------------------------------------------------------
  // expected bursts: remainder, both page ends and the burst limit
  task automatic plan_bursts(input addr_t src, input addr_t dst, input bytes_t n);
    addr_t  s;
    addr_t  d;
    bytes_t left;
    bytes_t chunk;
    s    = src;
    d    = dst;
    left = n;
    while (left != 0) begin
      chunk = left;
      if (chunk > BurstBytes) chunk = BurstBytes;
      if (chunk > PageBytes - s % PageBytes) chunk = PageBytes - s % PageBytes;
      if (chunk > PageBytes - d % PageBytes) chunk = PageBytes - d % PageBytes;
      exp_src.push_back(s);
      exp_dst.push_back(d);
      exp_len.push_back(len_t'(chunk / StrbWidth - 1));
      exp_req.push_back(req_idx);
      s    = s + chunk;
      d    = d + chunk;
      left = left - chunk;
    end
  endtask

  task automatic start_test(input int unsigned pct);
    stall_pct = pct;
    ar_log.delete();
    aw_log.delete();
    ar_done.delete();
    exp_src.delete();
    exp_dst.delete();
    exp_len.delete();
    exp_req.delete();
    req_idx    = 0;
    base_comp  = comp_cnt;
    base_waits = full_waits;
    test_errs  = err_cnt;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (err_cnt != test_errs) begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_cnt - test_errs);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // called on a falling edge, returns on the one after the push
  task automatic send_req(input addr_t src, input addr_t dst, input bytes_t n,
                          input logic ser);
    plan_bursts(src, dst, n);
    req_idx++;
    burst_req_i.src       = src;
    burst_req_i.dst       = dst;
    burst_req_i.num_bytes = n;
    burst_req_i.serialize = ser;
    valid_i = 1'b1;
    // ready_o follows the fifo count only, so it holds until the next edge
    while (!ready_o) begin
      full_waits++;
      @(negedge clk_i);
    end
    @(negedge clk_i);
    valid_i = 1'b0;
  endtask

  task automatic wait_quiet();
    @(negedge clk_i);
    while (!(backend_idle_o && rd_q.size() == 0 && wr_q.size() == 0 &&
             wbeat_q.size() == 0 && b_pend == 0)) begin
      @(negedge clk_i);
    end
    // completion trails the last write response by one cycle
    repeat (2) @(negedge clk_i);
  endtask

  task automatic check_copy(input addr_t src, input addr_t dst, input bytes_t n);
    for (bytes_t off = '0; off < n; off += bytes_t'(StrbWidth)) begin
      check_word(mem_word(dst + off), fill_word(src + off), "copied word");
    end
  endtask

  // ordered: each ar must follow the completion of the request before
  task automatic check_bursts(input logic ordered);
    int n;
    check_count(ar_log.size(), exp_len.size(), "ar burst count");
    check_count(aw_log.size(), exp_len.size(), "aw burst count");
    n = exp_len.size();
    if (ar_log.size() < n) n = ar_log.size();
    if (aw_log.size() < n) n = aw_log.size();
    for (int i = 0; i < n; i++) begin
      check_addr(ar_log[i].addr, exp_src[i], "ar address");
      check_len(ar_log[i].len, exp_len[i], "ar length");
      check_addr(aw_log[i].addr, exp_dst[i], "aw address");
      check_len(aw_log[i].len, exp_len[i], "aw length");
      if (ordered) check_count(ar_done[i] - base_comp, exp_req[i], "completions before ar");
    end
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic test_single_copy();
    start_test(20);
    send_req(32'h0000_0100, 32'h0000_8000, 64, 1'b1);
    wait_quiet();
    check_copy(32'h0000_0100, 32'h0000_8000, 64);
    check_count(comp_cnt - base_comp, 1, "completion pulses");
    check_bursts(1'b0);
    finish_test("aligned copy");
  endtask

  // source crosses 0x1000, destination crosses 0xa000
  task automatic test_page_split();
    start_test(20);
    send_req(32'h0000_0fc8, 32'h0000_9f90, 192, 1'b0);
    wait_quiet();
    check_copy(32'h0000_0fc8, 32'h0000_9f90, 192);
    check_count(comp_cnt - base_comp, 1, "completion pulses");
    check_bursts(1'b0);
    finish_test("page split");
  endtask

  task automatic test_zero_bytes();
    start_test(20);
    send_req(32'h0000_1800, 32'h0000_9000, 0, 1'b0);
    // first look is the cycle the dropped request sits at the fifo head
    repeat (20) begin
      if (!backend_idle_o) begin
        $display("backend_idle_o dropped at %0t on a zero-byte request", $time);
        err_cnt++;
      end
      @(negedge clk_i);
    end
    check_count(comp_cnt - base_comp, 0, "completion pulses");
    check_bursts(1'b0);
    finish_test("zero-byte request");
  endtask

  task automatic test_serialized_chain();
    start_test(20);
    for (int k = 0; k < 3; k++) begin
      send_req(32'h0000_2000 + k * 64, 32'h0000_a800 + k * 64, 64, 1'b1);
    end
    wait_quiet();
    for (int k = 0; k < 3; k++) begin
      check_copy(32'h0000_2000 + k * 64, 32'h0000_a800 + k * 64, 64);
    end
    check_count(comp_cnt - base_comp, 3, "completion pulses");
    check_count(full_waits - base_waits, 0, "request cycles blocked by ready_o");
    check_bursts(1'b1);
    finish_test("serialized chain");
  endtask

  // six requests overflow the request fifo, heavy stalls on every channel
  task automatic test_backpressure_stream();
    start_test(70);
    for (int k = 0; k < 6; k++) begin
      send_req(32'h0000_3f80 + k * 80, 32'h0000_c000 + k * 100, 80, 1'b0);
    end
    wait_quiet();
    for (int k = 0; k < 6; k++) begin
      check_copy(32'h0000_3f80 + k * 80, 32'h0000_c000 + k * 100, 80);
    end
    check_count(comp_cnt - base_comp, 6, "completion pulses");
    // first request holds the reshaper for three descriptors,
    // so the sixth push meets a full fifo for one cycle
    check_count(full_waits - base_waits, 1, "request cycles blocked by ready_o");
    check_bursts(1'b0);
    finish_test("back-pressure stream");
  endtask

  // --------------------------------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin
    void'($urandom(32'h433d_0182));
    for (int i = 0; i < 65536; i++) begin
      mem[16'(i)] = fill_byte(addr_t'(i));
    end
    rst_ni      = 1'b0;
    valid_i     = 1'b0;
    burst_req_i = '0;
    ar_ready_i  = 1'b0;
    aw_ready_i  = 1'b0;
    w_ready_i   = 1'b0;
    r_i         = '0;
    r_valid_i   = 1'b0;
    b_valid_i   = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    test_single_copy();
    test_page_split();
    test_zero_bytes();
    test_serialized_chain();
    test_backpressure_stream();
    $display("summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("watchdog: tests did not finish within %0d cycles", WatchdogCycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- tests/dma_backend_asserts.sv
// --------------------------------------------------------------------------
// dma backend bus checks
// valid held with stable payload until ready, one-cycle completion pulse,
// no address burst crossing a 4 KiB page
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module dma_backend_asserts (
  input logic              clk_i,
  input logic              rst_ni,
  input dma_pkg::ax_chan_t ar_o,
  input logic              ar_valid_o,
  input logic              ar_ready_i,
  input dma_pkg::ax_chan_t aw_o,
  input logic              aw_valid_o,
  input logic              aw_ready_i,
  input dma_pkg::w_chan_t  w_o,
  input logic              w_valid_o,
  input logic              w_ready_i,
  input dma_pkg::r_chan_t  r_i,
  input logic              r_valid_i,
  input logic              r_ready_o,
  input logic              b_valid_i,
  input logic              b_ready_o,
  input logic              trans_complete_o
);

  import dma_pkg::*;

  localparam int unsigned PageBits = $clog2(PageBytes);

  logic [31:0] ar_end;
  logic [31:0] aw_end;

  // page offset just past the last byte of the burst
  assign ar_end = 32'(ar_o.addr[PageBits-1:0]) + (32'(ar_o.len) + 32'd1) * StrbWidth;
  assign aw_end = 32'(aw_o.addr[PageBits-1:0]) + (32'(aw_o.len) + 32'd1) * StrbWidth;

  // --------------------------------------------------------------------------
  // handshake stability
  // --------------------------------------------------------------------------
  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
    else $error("ar valid dropped or payload moved before ready");

  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
    else $error("aw valid dropped or payload moved before ready");

  w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o))
    else $error("w valid dropped or payload moved before ready");

  r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_i && !r_ready_o |=> r_valid_i && $stable(r_i))
    else $error("r valid dropped or payload moved before ready");

  b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_i && !b_ready_o |=> b_valid_i)
    else $error("b valid dropped before ready");

  // --------------------------------------------------------------------------
  // completion and page rule
  // --------------------------------------------------------------------------
  complete_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trans_complete_o |=> !trans_complete_o)
    else $error("completion pulse longer than one cycle");

  ar_in_page: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o |-> ar_end <= PageBytes)
    else $error("ar burst crosses a page boundary");

  aw_in_page: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o |-> aw_end <= PageBytes)
    else $error("aw burst crosses a page boundary");

endmodule

bind dma_backend dma_backend_asserts i_asserts (.*);

//--- verilog/dma_backend.sv
// --------------------------------------------------------------------------
// 1d dma backend top
// request fifo, burst reshaper and data mover on an axi-style bus
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module dma_backend #(
  parameter int unsigned ReqDepth    = 4,
  parameter int unsigned QueueDepth  = 4,
  parameter int unsigned BufferDepth = 8,
  parameter int unsigned MaxBeats    = dma_pkg::MaxBeats
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                valid_i,
  input  dma_pkg::burst_req_t burst_req_i,
  output logic                ready_o,
  output dma_pkg::ax_chan_t   ar_o,
  output logic                ar_valid_o,
  input  logic                ar_ready_i,
  output dma_pkg::ax_chan_t   aw_o,
  output logic                aw_valid_o,
  input  logic                aw_ready_i,
  output dma_pkg::w_chan_t    w_o,
  output logic                w_valid_o,
  input  logic                w_ready_i,
  input  dma_pkg::r_chan_t    r_i,
  input  logic                r_valid_i,
  output logic                r_ready_o,
  input  logic                b_valid_i,
  output logic                b_ready_o,
  output logic                backend_idle_o,
  output logic                trans_complete_o
);

  import dma_pkg::*;

  burst_req_t  req;
  logic        req_full;
  logic        req_empty;
  logic        req_pop;
  burst_desc_t desc;
  logic        desc_valid;
  logic        desc_ready;
  logic        reshape_busy;
  logic        mover_idle;

  assign ready_o = ~req_full;

  dma_fifo #(.Depth(ReqDepth), .item_t(burst_req_t)) i_req_fifo (
    .clk_i, .rst_ni, .push_i(valid_i & ready_o), .data_i(burst_req_i),
    .pop_i(req_pop), .data_o(req), .full_o(req_full), .empty_o(req_empty));

  dma_burst_reshaper #(.MaxBeats(MaxBeats)) i_reshaper (
    .clk_i, .rst_ni, .req_i(req), .req_empty_i(req_empty), .req_pop_o(req_pop),
    .trans_complete_i(trans_complete_o), .desc_o(desc), .desc_valid_o(desc_valid),
    .desc_ready_i(desc_ready), .busy_o(reshape_busy));

  dma_data_mover #(.QueueDepth(QueueDepth), .BufferDepth(BufferDepth)) i_mover (
    .clk_i, .rst_ni, .desc_i(desc), .desc_valid_i(desc_valid), .desc_ready_o(desc_ready),
    .ar_o, .ar_valid_o, .ar_ready_i, .aw_o, .aw_valid_o, .aw_ready_i,
    .r_i, .r_valid_i, .r_ready_o, .w_o, .w_valid_o, .w_ready_i,
    .b_valid_i, .b_ready_o, .idle_o(mover_idle), .trans_complete_o);

  // a zero-byte request at the head causes no work
  assign backend_idle_o = (req_empty | (req.num_bytes == '0)) & ~reshape_busy & mover_idle;

endmodule

//--- verilog/dma_data_mover.sv
// --------------------------------------------------------------------------
// data mover
// issues ar and aw bursts from their own queues, passes read data through
// a word buffer to w and signals completion on the final write response
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module dma_data_mover #(
  parameter int unsigned QueueDepth  = 4,
  parameter int unsigned BufferDepth = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  dma_pkg::burst_desc_t desc_i,
  input  logic                 desc_valid_i,
  output logic                 desc_ready_o,
  output dma_pkg::ax_chan_t    ar_o,
  output logic                 ar_valid_o,
  input  logic                 ar_ready_i,
  output dma_pkg::ax_chan_t    aw_o,
  output logic                 aw_valid_o,
  input  logic                 aw_ready_i,
  input  dma_pkg::r_chan_t     r_i,
  input  logic                 r_valid_i,
  output logic                 r_ready_o,
  output dma_pkg::w_chan_t     w_o,
  output logic                 w_valid_o,
  input  logic                 w_ready_i,
  input  logic                 b_valid_i,
  output logic                 b_ready_o,
  output logic                 idle_o,
  output logic                 trans_complete_o
);

  import dma_pkg::*;

  // reads in flight never exceed the w length queue
  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  logic                desc_push;
  ax_chan_t            ar_in;
  ax_chan_t            aw_in;
  logic                ar_full;
  logic                ar_empty;
  logic                aw_full;
  logic                aw_empty;
  logic                wlen_full;
  logic                wlen_empty;
  logic                wlen_pop;
  len_t                wlen_head;
  logic                blast_full;
  logic                blast_empty;
  logic                blast_head;
  logic                buf_full;
  logic                buf_empty;
  data_t               buf_head;
  logic                ar_fire;
  logic                aw_fire;
  logic                r_fire;
  logic                w_fire;
  logic                b_fire;
  logic [CntWidth-1:0] rd_out_q;
  len_t                w_cnt_q;
  logic                complete_q;

  // --------------------------------------------------------------------------
  // descriptor fan-out
  // --------------------------------------------------------------------------
  // take a burst only when every queue has room
  assign desc_ready_o = ~ar_full & ~aw_full & ~wlen_full & ~blast_full;
  assign desc_push    = desc_valid_i & desc_ready_o;

  assign ar_in.addr = desc_i.src;
  assign ar_in.len  = desc_i.len;
  assign aw_in.addr = desc_i.dst;
  assign aw_in.len  = desc_i.len;

  dma_fifo #(.Depth(QueueDepth), .item_t(ax_chan_t)) i_ar_queue (
    .clk_i, .rst_ni, .push_i(desc_push), .data_i(ar_in), .pop_i(ar_fire),
    .data_o(ar_o), .full_o(ar_full), .empty_o(ar_empty));

  dma_fifo #(.Depth(QueueDepth), .item_t(ax_chan_t)) i_aw_queue (
    .clk_i, .rst_ni, .push_i(desc_push), .data_i(aw_in), .pop_i(aw_fire),
    .data_o(aw_o), .full_o(aw_full), .empty_o(aw_empty));

  dma_fifo #(.Depth(QueueDepth), .item_t(len_t)) i_wlen_queue (
    .clk_i, .rst_ni, .push_i(desc_push), .data_i(desc_i.len), .pop_i(wlen_pop),
    .data_o(wlen_head), .full_o(wlen_full), .empty_o(wlen_empty));

  dma_fifo #(.Depth(QueueDepth), .item_t(logic)) i_blast_queue (
    .clk_i, .rst_ni, .push_i(desc_push), .data_i(desc_i.last), .pop_i(b_fire),
    .data_o(blast_head), .full_o(blast_full), .empty_o(blast_empty));

  // --------------------------------------------------------------------------
  // address channels
  // --------------------------------------------------------------------------
  assign ar_valid_o = ~ar_empty;
  assign aw_valid_o = ~aw_empty;
  assign ar_fire    = ar_valid_o & ar_ready_i;
  assign aw_fire    = aw_valid_o & aw_ready_i;

  // --------------------------------------------------------------------------
  // read data into buffer, buffer out to w
  // --------------------------------------------------------------------------
  // only ready while a read burst is outstanding
  assign r_ready_o = ~buf_full & (rd_out_q != '0);
  assign r_fire    = r_valid_i & r_ready_o;

  dma_fifo #(.Depth(BufferDepth), .item_t(data_t)) i_data_buffer (
    .clk_i, .rst_ni, .push_i(r_fire), .data_i(r_i.data), .pop_i(w_fire),
    .data_o(buf_head), .full_o(buf_full), .empty_o(buf_empty));

  assign w_valid_o = ~buf_empty & ~wlen_empty;
  assign w_o.data  = buf_head;
  assign w_o.last  = (w_cnt_q == wlen_head);
  assign w_fire    = w_valid_o & w_ready_i;
  assign wlen_pop  = w_fire & w_o.last;

  // --------------------------------------------------------------------------
  // write response and completion
  // --------------------------------------------------------------------------
  assign b_ready_o        = ~blast_empty;
  assign b_fire           = b_valid_i & b_ready_o;
  assign trans_complete_o = complete_q;

  assign idle_o = ar_empty & aw_empty & wlen_empty & blast_empty & buf_empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_out_q   <= '0;
      w_cnt_q    <= '0;
      complete_q <= 1'b0;
    end else begin
      rd_out_q <= rd_out_q + CntWidth'(ar_fire) - CntWidth'(r_fire & r_i.last);
      // beat counter restarts on w last
      if (w_fire) begin
        w_cnt_q <= w_o.last ? '0 : w_cnt_q + 1'b1;
      end
      complete_q <= b_fire & blast_head;
    end
  end

endmodule

//--- verilog/dma_burst_reshaper.sv
// --------------------------------------------------------------------------
// burst reshaper
// cuts a copy request into bursts that stay inside a 4 KiB page on both
// sides and never exceed the burst limit, holds serialized requests back
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module dma_burst_reshaper #(
  parameter int unsigned MaxBeats = dma_pkg::MaxBeats
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  dma_pkg::burst_req_t  req_i,
  input  logic                 req_empty_i,
  output logic                 req_pop_o,
  input  logic                 trans_complete_i,
  output dma_pkg::burst_desc_t desc_o,
  output logic                 desc_valid_o,
  input  logic                 desc_ready_i,
  output logic                 busy_o
);

  import dma_pkg::*;

  localparam int unsigned PageBits   = $clog2(PageBytes);
  localparam int unsigned WordBits   = $clog2(StrbWidth);
  localparam bytes_t      BurstBytes = bytes_t'(MaxBeats * StrbWidth);

  reshape_state_e state_q;
  reshape_state_e state_d;
  addr_t          src_q;
  addr_t          src_d;
  addr_t          dst_q;
  addr_t          dst_d;
  bytes_t         left_q;
  bytes_t         left_d;
  logic           in_flight_q;
  logic           in_flight_d;

  bytes_t src_to_page;
  bytes_t dst_to_page;
  bytes_t burst_bytes;
  logic   load;
  logic   accept;

  function automatic bytes_t min_bytes(bytes_t a, bytes_t b);
    return (a < b) ? a : b;
  endfunction

  // --------------------------------------------------------------------------
  // burst size
  // --------------------------------------------------------------------------
  // distance to the next page boundary
  assign src_to_page = bytes_t'(PageBytes) - bytes_t'(src_q[PageBits-1:0]);
  assign dst_to_page = bytes_t'(PageBytes) - bytes_t'(dst_q[PageBits-1:0]);

  // smallest of remainder, both page limits and the burst limit
  assign burst_bytes = min_bytes(min_bytes(left_q, BurstBytes),
                                 min_bytes(src_to_page, dst_to_page));

  assign desc_o.src  = src_q;
  assign desc_o.dst  = dst_q;
  assign desc_o.len  = len_t'((burst_bytes >> WordBits) - 1);
  assign desc_o.last = (burst_bytes == left_q);

  assign desc_valid_o = (state_q == SPLIT);
  assign accept       = desc_valid_o & desc_ready_i;
  assign busy_o       = (state_q != IDLE);

  // serialized requests wait for the previous completion
  assign req_pop_o = (state_q == IDLE) & ~req_empty_i & ~(req_i.serialize & in_flight_q);
  // zero-byte requests are popped and dropped
  assign load      = req_pop_o & (req_i.num_bytes != '0);

  // --------------------------------------------------------------------------
  // split fsm
  // --------------------------------------------------------------------------
  always_comb begin
    state_d     = state_q;
    src_d       = src_q;
    dst_d       = dst_q;
    left_d      = left_q;
    in_flight_d = in_flight_q;
    if (trans_complete_i) begin
      in_flight_d = 1'b0;
    end
    unique case (state_q)
      IDLE: begin
        if (load) begin
          src_d       = req_i.src;
          dst_d       = req_i.dst;
          left_d      = req_i.num_bytes;
          in_flight_d = 1'b1;
          state_d     = SPLIT;
        end
      end
      SPLIT: begin
        // advance both sides by the burst just taken
        if (accept) begin
          src_d  = src_q + addr_t'(burst_bytes);
          dst_d  = dst_q + addr_t'(burst_bytes);
          left_d = left_q - burst_bytes;
          if (desc_o.last) begin
            state_d = IDLE;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      in_flight_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      in_flight_q <= in_flight_d;
    end
  end

  always_ff @(posedge clk_i) begin
    src_q  <= src_d;
    dst_q  <= dst_d;
    left_q <= left_d;
  end

endmodule

//--- verilog/dma_fifo.sv
// --------------------------------------------------------------------------
// synchronous fifo with a type parameter
// register array, read data visible one cycle after the push
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module dma_fifo #(
  parameter int unsigned Depth  = 4,
  parameter type         item_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  item_t data_i,
  input  logic  pop_i,
  output item_t data_o,
  output logic  full_o,
  output logic  empty_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  item_t               mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_push;
  logic                do_pop;

  // pointer step with wrap at depth
  function automatic logic [PtrWidth-1:0] wrap_inc(logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CntWidth'(Depth));
  assign empty_o = (count_q == '0);

  // push on full and pop on empty are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wrap_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= wrap_inc(rd_ptr_q);
      end
      count_q <= count_q + CntWidth'(do_push) - CntWidth'(do_pop);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- verilog/dma_pkg.sv
// --------------------------------------------------------------------------
// dma backend shared definitions
// bus widths, burst limits and the channel structs of the copy engine
// --------------------------------------------------------------------------
package dma_pkg;

  // bus geometry
  parameter int unsigned AddrWidth = 32;
  parameter int unsigned DataWidth = 32;
  parameter int unsigned LenWidth  = 8;
  // bytes per bus word
  parameter int unsigned StrbWidth = DataWidth / 8;

  // axi page size, bursts must stay inside one page
  parameter int unsigned PageBytes = 4096;
  // upper limit for one burst, top level may lower it
  parameter int unsigned MaxBeats  = 16;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  // beats minus one, as on the bus
  typedef logic [LenWidth-1:0]  len_t;
  typedef logic [31:0]          bytes_t;

  // copy request as seen on the front port
  typedef struct packed {
    addr_t  src;
    addr_t  dst;
    bytes_t num_bytes;
    logic   serialize;
  } burst_req_t;

  // one page-safe burst, last marks the end of its request
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
    logic  last;
  } burst_desc_t;

  // shared by ar and aw
  typedef struct packed {
    addr_t addr;
    len_t  len;
  } ax_chan_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } r_chan_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } w_chan_t;

  typedef enum logic {
    IDLE,
    SPLIT
  } reshape_state_e;

endpackage
